//--- rtl/div_pkg.sv
`default_nettype none

package div_pkg;

  // ==============================
  // sizing
  // ==============================
  localparam int XLEN              = 64;
  localparam int HALF_W            = XLEN / 2;        // word op width
  localparam int NUM_LANES         = 4;
  localparam int LANE_IDX_W        = 2;
  localparam int REQ_FIFO_DEPTH    = 4;               // equals requester credits
  localparam int FIFO_IDX_W        = $clog2(REQ_FIFO_DEPTH);
  localparam int RESP_CREDITS_INIT = 2;
  localparam int RESP_CNT_W        = $clog2(RESP_CREDITS_INIT + 1);
  localparam int CNT_W             = 7;

  // op[2] word, op[1] remainder, op[0] unsigned
  typedef enum logic [2:0] {
    OP_DIV   = 3'd0,
    OP_DIVU  = 3'd1,
    OP_REM   = 3'd2,
    OP_REMU  = 3'd3,
    OP_DIVW  = 3'd4,
    OP_DIVUW = 3'd5,
    OP_REMW  = 3'd6,
    OP_REMUW = 3'd7
  } div_op_e;

  typedef struct packed {
    div_op_e         op;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    div_op_e          op;
    logic [XLEN-1:0]  dividend;   // magnitude, word ops left-justified
    logic [XLEN-1:0]  divisor;    // magnitude
    logic [CNT_W-1:0] iter_cnt;
    logic             q_neg;
    logic             r_neg;
    logic             exc;        // zero divisor or overflow
    logic [XLEN-1:0]  exc_val;    // final value, no iteration needed
  } div_work_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    div_op_e         op;
  } div_resp_t;

  // ==============================
  // op helpers
  // ==============================
  function automatic logic op_is_word(div_op_e op);
    return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic op_is_rem(div_op_e op);
    return op inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic op_is_signed(div_op_e op);
    return op inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW};
  endfunction

  function automatic logic [XLEN-1:0] sext_word(logic [XLEN-1:0] v);
    return {{HALF_W{v[HALF_W-1]}}, v[HALF_W-1:0]};
  endfunction

endpackage

`default_nettype wire

//--- rtl/div_precheck.sv
`default_nettype none

module div_precheck (
  input  div_pkg::div_req_t  req_i,
  output div_pkg::div_work_t work_o
);
  import div_pkg::*;

  logic            is_word;
  logic            is_rem;
  logic            is_sgn;
  logic [XLEN-1:0] a_ext;      // dividend after word extension
  logic [XLEN-1:0] b_ext;      // divisor after word extension
  logic [XLEN-1:0] a_sext;     // dividend as rem-by-zero returns it
  logic [XLEN-1:0] min_neg;    // most negative value at op width
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic            div_zero;
  logic            div_ovf;
  logic [XLEN-1:0] exc_val;

  // ==============================
  // decode and extension
  // ==============================
  always_comb begin
    is_word = op_is_word(req_i.op);
    is_rem  = op_is_rem(req_i.op);
    is_sgn  = op_is_signed(req_i.op);

    if (is_word) begin
      // upper operand bits are ignored for word ops
      if (is_sgn) begin
        a_ext = sext_word(req_i.dividend);
        b_ext = sext_word(req_i.divisor);
      end else begin
        a_ext = {{HALF_W{1'b0}}, req_i.dividend[HALF_W-1:0]};
        b_ext = {{HALF_W{1'b0}}, req_i.divisor[HALF_W-1:0]};
      end
      a_sext  = sext_word(req_i.dividend);  // remuw by zero too
      min_neg = {{(HALF_W+1){1'b1}}, {(HALF_W-1){1'b0}}};
    end else begin
      a_ext   = req_i.dividend;
      b_ext   = req_i.divisor;
      a_sext  = req_i.dividend;
      min_neg = {1'b1, {(XLEN-1){1'b0}}};
    end
  end

  // ==============================
  // exceptions and magnitudes
  // ==============================
  always_comb begin
    div_zero = (b_ext == '0);
    div_ovf  = is_sgn && (a_ext == min_neg) && (b_ext == '1);

    // riscv defined results, no trap
    if (div_zero) begin
      exc_val = is_rem ? a_sext : '1;
    end else if (div_ovf) begin
      exc_val = is_rem ? '0 : a_ext;
    end else begin
      exc_val = '0;
    end

    a_neg = is_sgn && a_ext[XLEN-1];
    b_neg = is_sgn && b_ext[XLEN-1];
    a_mag = a_neg ? -a_ext : a_ext;
    b_mag = b_neg ? -b_ext : b_ext;
  end

  always_comb begin
    work_o.op       = req_i.op;
    // word dividend goes to the upper half so 32 shifts consume it
    work_o.dividend = is_word ? {a_mag[HALF_W-1:0], {HALF_W{1'b0}}} : a_mag;
    work_o.divisor  = b_mag;
    work_o.iter_cnt = is_word ? CNT_W'(HALF_W) : CNT_W'(XLEN);
    work_o.q_neg    = a_neg ^ b_neg;
    work_o.r_neg    = a_neg;                // remainder follows dividend
    work_o.exc      = div_zero || div_ovf;
    work_o.exc_val  = exc_val;
  end

endmodule

`default_nettype wire

//--- rtl/div_dispatch.sv
`default_nettype none

module div_dispatch (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_valid_i,
  input  div_pkg::div_req_t              req_i,
  output logic                           req_credit_o,
  input  logic [div_pkg::NUM_LANES-1:0]  lane_idle_i,
  output logic [div_pkg::NUM_LANES-1:0]  issue_valid_o,
  output div_pkg::div_work_t             issue_work_o
);
  import div_pkg::*;

  div_req_t              fifo_mem [REQ_FIFO_DEPTH];
  logic [FIFO_IDX_W-1:0] wr_ptr_q;
  logic [FIFO_IDX_W-1:0] rd_ptr_q;
  logic [FIFO_IDX_W:0]   count_q;
  logic [LANE_IDX_W-1:0] lane_ptr_q;   // next lane in issue order
  logic                  issue_fire;

  // head entry goes through the checker every cycle
  div_precheck precheck_inst (
    .req_i  (fifo_mem[rd_ptr_q]),
    .work_o (issue_work_o)
  );

  assign issue_fire   = (count_q != '0) && lane_idle_i[lane_ptr_q];
  assign req_credit_o = issue_fire;    // slot freed, credit back

  always_comb begin
    issue_valid_o = '0;
    issue_valid_o[lane_ptr_q] = issue_fire;
  end

  // ==============================
  // request FIFO
  // ==============================
  // requester holds a credit, so a write never finds the FIFO full
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      fifo_mem[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_IDX_W'(REQ_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (issue_fire) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_IDX_W'(REQ_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (FIFO_IDX_W+1)'(req_valid_i) - (FIFO_IDX_W+1)'(issue_fire);
    end
  end

  // ==============================
  // round-robin lane pointer
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      lane_ptr_q <= '0;
    end else if (issue_fire) begin
      // strict order, collector walks the same sequence
      lane_ptr_q <= (lane_ptr_q == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : lane_ptr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/div_lane.sv
`default_nettype none

module div_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue_valid_i,
  input  div_pkg::div_work_t issue_work_i,
  input  logic               take_i,
  output logic               idle_o,
  output logic               done_o,
  output div_pkg::div_resp_t result_o
);
  import div_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ITER,
    ST_FIN
  } lane_state_e;

  lane_state_e       state_q;
  logic [CNT_W-1:0]  cnt_q;        // iterations left
  logic [2*XLEN-1:0] acc_q;        // remainder:quotient
  logic [XLEN-1:0]   dvsr_q;
  div_op_e           op_q;
  logic              q_neg_q;
  logic              r_neg_q;
  logic              exc_q;
  logic [XLEN-1:0]   exc_val_q;
  logic [XLEN-1:0]   res_q;

  logic              load;
  logic [XLEN:0]     trial;        // shifted remainder minus divisor
  logic [2*XLEN-1:0] acc_next;
  logic [XLEN-1:0]   quo_fix;
  logic [XLEN-1:0]   rem_fix;
  logic [XLEN-1:0]   pick;
  logic [XLEN-1:0]   final_res;

  assign load = (state_q == ST_IDLE) && issue_valid_i;

  // ==============================
  // one restoring step
  // ==============================
  always_comb begin
    // acc_q[2*XLEN-1:XLEN-1] is the upper half after the left shift
    trial = acc_q[2*XLEN-1:XLEN-1] - {1'b0, dvsr_q};
    if (trial[XLEN]) begin
      acc_next = {acc_q[2*XLEN-2:0], 1'b0};                  // restore
    end else begin
      acc_next = {trial[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};   // keep difference
    end
  end

  // result fix-up from the finished register
  always_comb begin
    quo_fix   = q_neg_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
    rem_fix   = r_neg_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];
    pick      = op_is_rem(op_q) ? rem_fix : quo_fix;
    final_res = op_is_word(op_q) ? sext_word(pick) : pick;
  end

  // ==============================
  // control
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (issue_valid_i) begin
            state_q <= ST_ITER;
            cnt_q   <= issue_work_i.iter_cnt;
          end
        end
        ST_ITER: begin
          if (exc_q || cnt_q == '0) begin
            state_q <= ST_FIN;          // result registered on this edge
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ST_FIN: begin
          if (take_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ==============================
  // datapath
  // ==============================
  always_ff @(posedge clk) begin
    if (load) begin
      acc_q     <= {{XLEN{1'b0}}, issue_work_i.dividend};
      dvsr_q    <= issue_work_i.divisor;
      op_q      <= issue_work_i.op;
      q_neg_q   <= issue_work_i.q_neg;
      r_neg_q   <= issue_work_i.r_neg;
      exc_q     <= issue_work_i.exc;
      exc_val_q <= issue_work_i.exc_val;
    end else if (state_q == ST_ITER) begin
      if (exc_q) begin
        res_q <= exc_val_q;            // skips the divider entirely
      end else if (cnt_q == '0) begin
        res_q <= final_res;
      end else begin
        acc_q <= acc_next;
      end
    end
  end

  assign idle_o          = (state_q == ST_IDLE);
  assign done_o          = (state_q == ST_FIN);   // held until take
  assign result_o.result = res_q;
  assign result_o.op     = op_q;

endmodule

`default_nettype wire

//--- rtl/div_collect.sv
`default_nettype none

module div_collect (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [div_pkg::NUM_LANES-1:0]            done_i,
  input  div_pkg::div_resp_t [div_pkg::NUM_LANES-1:0] lane_result_i,
  output logic [div_pkg::NUM_LANES-1:0]            take_o,
  input  logic                                     resp_credit_i,
  output logic                                     resp_valid_o,
  output div_pkg::div_resp_t                       resp_o
);
  import div_pkg::*;

  logic [LANE_IDX_W-1:0] lane_ptr_q;   // oldest lane still owed a result
  logic [RESP_CNT_W-1:0] credits_q;
  logic                  take_fire;

  // a later lane may be done first, it just waits its turn
  assign take_fire = done_i[lane_ptr_q] && (credits_q != '0);

  always_comb begin
    take_o = '0;
    take_o[lane_ptr_q] = take_fire;
  end

  // ==============================
  // pointer and credits
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      lane_ptr_q <= '0;
      credits_q  <= RESP_CNT_W'(RESP_CREDITS_INIT);
    end else begin
      if (take_fire) begin
        lane_ptr_q <= (lane_ptr_q == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : lane_ptr_q + 1'b1;
      end
      // credit spent at take, send follows one cycle later
      credits_q <= credits_q - RESP_CNT_W'(take_fire) + RESP_CNT_W'(resp_credit_i);
    end
  end

  // ==============================
  // output register
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= take_fire;       // single cycle per result
    end
  end

  always_ff @(posedge clk) begin
    if (take_fire) begin
      resp_o <= lane_result_i[lane_ptr_q];
    end
  end

endmodule

`default_nettype wire

//--- rtl/div_unit.sv
`default_nettype none

module div_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  div_pkg::div_req_t  req_i,
  output logic               req_credit_o,
  output logic               resp_valid_o,
  output div_pkg::div_resp_t resp_o,
  input  logic               resp_credit_i
);
  import div_pkg::*;

  logic [NUM_LANES-1:0]            lane_idle;
  logic [NUM_LANES-1:0]            issue_valid;
  div_work_t                       issue_work;   // shared by all lanes
  logic [NUM_LANES-1:0]            done;
  logic [NUM_LANES-1:0]            take;
  div_resp_t [NUM_LANES-1:0]       lane_result;

  div_dispatch dispatch_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .lane_idle_i   (lane_idle),
    .issue_valid_o (issue_valid),
    .issue_work_o  (issue_work)
  );

  // ==============================
  // divider lanes
  // ==============================
  for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lane
    div_lane lane_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue_valid_i (issue_valid[k]),
      .issue_work_i  (issue_work),
      .take_i        (take[k]),
      .idle_o        (lane_idle[k]),
      .done_o        (done[k]),
      .result_o      (lane_result[k])
    );
  end

  div_collect collect_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .done_i        (done),
    .lane_result_i (lane_result),
    .take_o        (take),
    .resp_credit_i (resp_credit_i),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o)
  );

endmodule

`default_nettype wire

//--- verif/div_unit_tb.sv
`default_nettype none

module div_unit_tb;
  import div_pkg::*;

  localparam int NUM_OPS = 96;   // all directed and random requests

  logic      clk = 1'b0;
  logic      rst_n;
  logic      req_valid_i;
  div_req_t  req_i;
  logic      req_credit_o;
  logic      resp_valid_o;
  div_resp_t resp_o;
  logic      resp_credit_i;

  div_resp_t   exp_q[$];        // expected results in send order
  int          credits = REQ_FIFO_DEPTH;
  int          sent_cnt = 0;
  int          credit_cnt = 0;  // input credits returned so far
  int          resp_cnt = 0;
  int          owed = 0;        // output slots not yet returned
  logic        credit_on = 1'b1;
  int          err_cnt = 0;
  int          other_cnt = 0;
  logic [31:0] lfsr_q = 32'h177b6708;

  div_unit div_unit_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .resp_credit_i (resp_credit_i)
  );

  always #5 clk = ~clk;

  // ==============================
  // helpers
  // ==============================
  task automatic check(logic [63:0] got, logic [63:0] exp, string msg);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // riscv M-extension results with truncating division
  function automatic logic [63:0] ref_result(div_op_e op, logic [63:0] a, logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic               ovf;      // most negative over minus one
    logic               ovf_w;
    logic        [31:0] wr;
    logic        [63:0] r;
    sa    = a;
    sb    = b;
    wa    = a[31:0];
    wb    = b[31:0];
    ovf   = (a == 64'h8000_0000_0000_0000) && (b == '1);
    ovf_w = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
    r     = '0;
    wr    = '0;
    case (op)
      OP_DIV:   r = (b == 0) ? '1 : ovf ? a : $unsigned(sa / sb);
      OP_REM:   r = (b == 0) ? a : ovf ? '0 : $unsigned(sa % sb);
      OP_DIVU:  r = (b == 0) ? '1 : a / b;
      OP_REMU:  r = (b == 0) ? a : a % b;
      OP_DIVW:  wr = (wb == 0) ? '1 : ovf_w ? a[31:0] : $unsigned(wa / wb);
      OP_REMW:  wr = (wb == 0) ? a[31:0] : ovf_w ? '0 : $unsigned(wa % wb);
      OP_DIVUW: wr = (b[31:0] == 0) ? '1 : a[31:0] / b[31:0];
      OP_REMUW: wr = (b[31:0] == 0) ? a[31:0] : a[31:0] % b[31:0];
      default:  r = '0;
    endcase
    if (op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW}) begin
      r = {{32{wr[31]}}, wr};   // word results always sign-extend
    end
    return r;
  endfunction

  // called 1 unit after a rising edge
  task automatic send(div_op_e op, logic [63:0] a, logic [63:0] b);
    div_resp_t e;
    while (credits == 0) begin
      @(posedge clk);
      #1;
    end
    credits--;
    sent_cnt++;
    e.result = ref_result(op, a, b);
    e.op     = op;
    exp_q.push_back(e);
    req_i.op       = op;
    req_i.dividend = a;
    req_i.divisor  = b;
    req_valid_i    = 1'b1;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic send_group(logic word, logic [63:0] a, logic [63:0] b);
    for (int i = 0; i < 4; i++) begin
      send(div_op_e'({word, i[1:0]}), a, b);
    end
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ==============================
  // credit return and response check
  // ==============================
  always @(posedge clk) begin
    if (!rst_n && req_credit_o) begin
      credits++;
      credit_cnt++;
    end
  end

  always @(posedge clk) begin
    if (!rst_n && resp_valid_o) begin
      owed++;
    end
    #1;
    if (credit_on && owed > 0) begin
      resp_credit_i = 1'b1;
      owed--;
    end else begin
      resp_credit_i = 1'b0;
    end
  end

  always @(posedge clk) begin
    div_resp_t e;
    if (!rst_n && resp_valid_o) begin
      if (exp_q.size() == 0) begin
        other_cnt++;
        $display("response at %0t arrived with nothing outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check(resp_o.result, e.result, $sformatf("resp %0d result", resp_cnt));
        check(64'(resp_o.op), 64'(e.op), $sformatf("resp %0d op", resp_cnt));
      end
      resp_cnt++;
    end
  end

  // ==============================
  // tests
  // ==============================
  task automatic dword_ops();
    send_group(1'b0, 64'd100, 64'd7);
    send_group(1'b0, -64'd100, 64'd7);
    send_group(1'b0, 64'd100, -64'd7);
    send_group(1'b0, -64'd100, -64'd7);
    send_group(1'b0, 64'hdead_beef_0123_4567, 64'h0000_0000_0000_0fff);
    wait_drain();
  endtask

  task automatic word_ops();
    send_group(1'b1, 64'hffff_0000_0000_0064, 64'h1234_5678_ffff_fff9);  // upper bits garbage
    send_group(1'b1, 64'h0bad_0000_ffff_ff9c, 64'h0000_0001_0000_0007);
    send_group(1'b1, 64'h5555_5555_8000_0001, 64'haaaa_0000_0000_0003);
    wait_drain();
  endtask

  task automatic exception_results();
    send_group(1'b0, 64'h8000_0000_0000_0005, 64'h0);
    send_group(1'b1, 64'h0000_0000_8000_0005, 64'hffff_ffff_0000_0000);  // word divisor zero
    send(OP_DIV, 64'h8000_0000_0000_0000, '1);
    send(OP_REM, 64'h8000_0000_0000_0000, '1);
    send(OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    send(OP_REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    wait_drain();
  endtask

  task automatic random_stream();
    div_op_e     op;
    logic [63:0] a;
    logic [63:0] b;
    for (int i = 0; i < 40; i++) begin
      op = div_op_e'(rand_bits(3));
      a  = rand_bits(64);
      b  = rand_bits(64);
      b  = b >> rand_bits(6);         // spread of divisor sizes
      if (rand_bits(3) == 0) begin
        b = '0;
      end
      send(op, a, b);
    end
    wait_drain();
  endtask

  task automatic credit_stall();
    int          resp_base;
    int          credit_snap;
    div_op_e     op;
    logic [63:0] a;
    logic [63:0] b;
    wait_cycles(2);                   // last output credit goes back first
    resp_base = resp_cnt;
    credit_on = 1'b0;
    fork
      begin
        for (int i = 0; i < 12; i++) begin
          op = div_op_e'(rand_bits(2));
          a  = rand_bits(64);
          b  = rand_bits(40);
          send(op, a, b);
        end
      end
      begin
        wait_cycles(300);
        credit_snap = credit_cnt;
        wait_cycles(150);
        check(64'(credit_cnt), 64'(credit_snap), "input credits while stalled");
        check(64'(resp_cnt - resp_base), 64'(RESP_CREDITS_INIT), "responses while stalled");
        credit_on = 1'b1;
      end
    join
    wait_drain();
    check(64'(credit_cnt), 64'(sent_cnt), "input credits returned");
  endtask

  // ==============================
  // main sequence and watchdog
  // ==============================
  initial begin
    rst_n         = 1'b1;
    req_valid_i   = 1'b0;
    req_i         = '0;
    resp_credit_i = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b0;
    wait_cycles(2);
    dword_ops();
    word_ops();
    exception_results();
    random_stream();
    credit_stall();
    wait_cycles(5);
    $display("errors: %0d check, %0d other", err_cnt, other_cnt);
    if (err_cnt == 0 && other_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_OPS * 80 + 2000) @(posedge clk);
    $display("timeout, run did not finish, %0d results outstanding", exp_q.size());
    $display("errors: %0d check, %0d other", err_cnt, other_cnt);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- div_unit.f
rtl/div_pkg.sv
rtl/div_precheck.sv
rtl/div_dispatch.sv
rtl/div_lane.sv
rtl/div_collect.sv
rtl/div_unit.sv
verif/div_unit_tb.sv
